// File: design/fetchPkg.sv
// ========================================
// Shared types and constants for the fetch front end.
// There is a single credit pool
// ========================================
package fetchPkg;

    // ========================================
    // Word and field types
    // ========================================

    // Program address, byte granular
    typedef logic [31:0] addrWord;

    typedef logic [31:0] instrWord;

    // Signed byte offset for B and execute redirects
    typedef logic [15:0] imm16;

    // Major opcode, instruction bits 31 to 25
    typedef logic [6:0] opcodeField;

    // Micro-op number within one MUL expansion
    typedef logic [1:0] stepIndex;

    typedef logic [2:0] creditCount;

    // ========================================
    // Constants
    // ========================================

    localparam opcodeField opBranch = 7'b1100000;
    localparam opcodeField opNop    = 7'b1100100;
    localparam opcodeField opMul    = 7'b1010000;

    // Fixed shift-add run per MUL
    localparam int mulSteps = 4;

    // Sequential fetch stride
    localparam addrWord instrBytes = 32'd4;

    // Execute slots free after reset
    localparam creditCount creditMax = 3'd4;

    // ========================================
    // State and packet types
    // ========================================

    typedef enum logic [1:0] {
        seqIdle   = 2'd0,
        seqFilter = 2'd1,
        seqUcode  = 2'd2
    } seqState;

    typedef enum logic {
        kindInstr = 1'b0,
        kindMicro = 1'b1
    } issueKind;

    // Step is zero for plain instructions
    typedef struct packed {
        issueKind kind;
        addrWord  pc;
        instrWord instr;
        stepIndex step;
    } issuePacket;

endpackage

// File: design/pcSequencer.sv
// ========================================
// Fetch happens only while issueReady is high. Override
// from execute wins over the fetched word
// ========================================
`timescale 1ns/100ps

module pcSequencer
    import fetchPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  instrWord   fetchedInstruction,
    input  logic       exeOverride,
    input  imm16       exeData,
    input  logic       issueReady,
    input  logic       mulDone,
    output addrWord    programCounter,
    output logic       fetchTake,
    output logic       instrValid,
    output issuePacket instrPacket,
    output logic       mulStart,
    output instrWord   mulInstr
);

    seqState    state;
    seqState    stateNext;
    addrWord    pcNext;
    opcodeField opcode;
    imm16       branchImm;
    addrWord    branchOffset;
    addrWord    exeOffset;
    logic       isBranch;
    logic       isNop;
    logic       isMul;

    // ========================================
    // Decode
    // ========================================

    assign opcode    = fetchedInstruction[31:25];
    assign branchImm = fetchedInstruction[15:0];
    assign isBranch  = (opcode == opBranch);
    assign isNop     = (opcode == opNop);
    assign isMul     = (opcode == opMul);

    // Sign extended byte offsets
    assign branchOffset = {{16{branchImm[15]}}, branchImm};
    assign exeOffset    = {{16{exeData[15]}}, exeData};

    // Plain and B instructions go out with their own pc
    assign instrPacket = '{
        kind:  kindInstr,
        pc:    programCounter,
        instr: fetchedInstruction,
        step:  '0
    };

    // The microcode block latches this on mulStart
    assign mulInstr = fetchedInstruction;

    // ========================================
    // Next state and next PC
    // ========================================

    always_comb begin
        stateNext  = state;
        pcNext     = programCounter;
        fetchTake  = 1'b0;
        instrValid = 1'b0;
        mulStart   = 1'b0;

        case (state)
            seqIdle: begin
                stateNext = seqFilter;
            end

            seqFilter: begin
                // Nothing moves without a free credit
                if (issueReady) begin
                    fetchTake = 1'b1;
                    if (exeOverride) begin
                        // Squash this cycle's word
                        pcNext = programCounter + exeOffset;
                    end else if (isBranch) begin
                        pcNext     = programCounter + branchOffset;
                        instrValid = 1'b1;
                    end else if (isNop) begin
                        pcNext = programCounter + instrBytes;
                    end else if (isMul) begin
                        // PC stays on the MUL during expansion
                        mulStart  = 1'b1;
                        stateNext = seqUcode;
                    end else begin
                        pcNext     = programCounter + instrBytes;
                        instrValid = 1'b1;
                    end
                end
            end

            seqUcode: begin
                if (mulDone) begin
                    pcNext    = programCounter + instrBytes;
                    stateNext = seqFilter;
                end
            end

            default: begin
                stateNext = seqIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= seqIdle;
            programCounter <= '0;
        end else begin
            state          <= stateNext;
            programCounter <= pcNext;
        end
    end

endmodule

// File: design/mulMicrocode.sv
// ========================================
// One MUL at a time. The sequencer sends no mulStart
// while a run is in progress
// ========================================
`timescale 1ns/100ps

module mulMicrocode
    import fetchPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       mulStart,
    input  instrWord   mulInstr,
    input  addrWord    pc,
    input  logic       issueReady,
    output logic       microValid,
    output issuePacket microPacket,
    output logic       mulDone
);

    logic     active;
    stepIndex step;
    logic     lastStep;
    instrWord mulWord;
    addrWord  mulPc;

    assign lastStep = (step == stepIndex'(mulSteps - 1));

    // One micro-op offered per cycle while active
    assign microValid = active;
    assign microPacket = '{
        kind:  kindMicro,
        pc:    mulPc,
        instr: mulWord,
        step:  step
    };

    // Same cycle as acceptance of the last step
    assign mulDone = active && issueReady && lastStep;

    // ========================================
    // Step counter
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            step   <= '0;
        end else if (mulStart && !active) begin
            active <= 1'b1;
            step   <= '0;
        end else if (active && issueReady) begin
            step <= step + stepIndex'(1);
            if (lastStep) begin
                active <= 1'b0;
            end
        end
    end

    // MUL word and its pc hold for the whole run
    always_ff @(posedge clk) begin
        if (mulStart && !active) begin
            mulWord <= mulInstr;
            mulPc   <= pc;
        end
    end

endmodule

// File: design/issueMerge.sv
// ========================================
// Single credit pool capped at creditMax. A credit
// returned this cycle can be spent this cycle
// ========================================
`timescale 1ns/100ps

module issueMerge
    import fetchPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       instrValid,
    input  issuePacket instrPacket,
    input  logic       microValid,
    input  issuePacket microPacket,
    input  logic       creditReturn,
    output logic       issueReady,
    output logic       issueValid,
    output issuePacket issueOut
);

    creditCount credits;
    creditCount creditsAfterReturn;
    creditCount creditsNext;
    logic       accept;
    issuePacket selected;

    // ========================================
    // Credit accounting
    // ========================================

    // Returned credit counts before the ready decision
    assign creditsAfterReturn = creditReturn ? credits + creditCount'(1) : credits;

    assign issueReady = (creditsAfterReturn != '0);

    // Microcode has priority over plain instructions
    assign accept   = issueReady && (microValid || instrValid);
    assign selected = microValid ? microPacket : instrPacket;

    always_comb begin
        creditsNext = creditsAfterReturn;
        if (accept) begin
            creditsNext = creditsNext - creditCount'(1);
        end
        // Stray returns beyond the pool are dropped
        if (creditsNext > creditMax) begin
            creditsNext = creditMax;
        end
    end

    // ========================================
    // Issue register
    // ========================================

    always_ff @(posedge clk) begin
        if (rst) begin
            credits    <= creditMax;
            issueValid <= 1'b0;
        end else begin
            credits    <= creditsNext;
            issueValid <= accept;
        end
    end

    // Payload loads only on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            issueOut <= selected;
        end
    end

endmodule

// File: design/fetchFrontEnd.sv
// ========================================
// Instruction memory and execute are outside. The memory
// must answer combinationally for programCounter
// ========================================
`timescale 1ns/100ps

module fetchFrontEnd
    import fetchPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  instrWord   fetchedInstruction,
    input  logic       exeOverride,
    input  imm16       exeData,
    input  logic       creditReturn,
    output addrWord    programCounter,
    output logic       fetchTake,
    output logic       issueValid,
    output issuePacket issueOut
);

    // Links between the three blocks
    logic       issueReady;
    logic       instrValid;
    issuePacket instrPacket;
    logic       mulStart;
    instrWord   mulInstr;
    logic       mulDone;
    logic       microValid;
    issuePacket microPacket;

    pcSequencer seq0 (
        .clk                (clk),
        .rst                (rst),
        .fetchedInstruction (fetchedInstruction),
        .exeOverride        (exeOverride),
        .exeData            (exeData),
        .issueReady         (issueReady),
        .mulDone            (mulDone),
        .programCounter     (programCounter),
        .fetchTake          (fetchTake),
        .instrValid         (instrValid),
        .instrPacket        (instrPacket),
        .mulStart           (mulStart),
        .mulInstr           (mulInstr)
    );

    // PC holds on the MUL, so it doubles as the micro-op pc
    mulMicrocode ucode0 (
        .clk         (clk),
        .rst         (rst),
        .mulStart    (mulStart),
        .mulInstr    (mulInstr),
        .pc          (programCounter),
        .issueReady  (issueReady),
        .microValid  (microValid),
        .microPacket (microPacket),
        .mulDone     (mulDone)
    );

    issueMerge merge0 (
        .clk          (clk),
        .rst          (rst),
        .instrValid   (instrValid),
        .instrPacket  (instrPacket),
        .microValid   (microValid),
        .microPacket  (microPacket),
        .creditReturn (creditReturn),
        .issueReady   (issueReady),
        .issueValid   (issueValid),
        .issueOut     (issueOut)
    );

endmodule

// File: test/fetchFrontEndTb.sv
// ========================================
// Run from the project root. The memory and the execute
// model are fed from test/fetchCases.txt
// ========================================
`timescale 1ns/100ps

module fetchFrontEndTb
    import fetchPkg::*;
();

    localparam int maxRecords  = 40;
    localparam int recordWords = 5;
    // Credits are withheld for a while once this case is fetched
    localparam int holdRecord  = 17;
    localparam int holdCycles  = 24;

    logic       clk = 1'b0;
    logic       rst = 1'b1;
    instrWord   fetchedInstruction = '0;
    logic       exeOverride = 1'b0;
    imm16       exeData = '0;
    logic       creditReturn = 1'b0;
    addrWord    programCounter;
    logic       fetchTake;
    logic       issueValid;
    issuePacket issueOut;

    // Word 0 is the record count, then five words per record
    logic [31:0] caseMem [0:maxRecords*recordWords];

    int          numRecords;
    int          timeLimit;
    int          endErrors;
    int          cycle = 0;
    int          errorCount = 0;
    int          caseErrors = 0;
    int          casesPassed = 0;
    int          casesFailed = 0;
    int          recIdx = 0;
    int          takenIdx = -1;
    int          takeCycle = 0;
    int          gotCount = 0;
    int          issuedTotal = 0;
    int          returnedTotal = 0;
    int          outBefore = 0;
    int          stallCycles = 0;
    int          holdLeft = 0;
    int          delay = 0;
    addrWord     takePc = '0;
    addrWord     expNextPc = '0;
    instrWord    takenInstr = '0;
    logic [31:0] expCount = '0;
    logic        finished = 1'b0;
    logic [31:0] lfsrState = 32'hc611_af34;
    int          dueQueue [$];

    fetchFrontEnd dut0 (
        .clk                (clk),
        .rst                (rst),
        .fetchedInstruction (fetchedInstruction),
        .exeOverride        (exeOverride),
        .exeData            (exeData),
        .creditReturn       (creditReturn),
        .programCounter     (programCounter),
        .fetchTake          (fetchTake),
        .issueValid         (issueValid),
        .issueOut           (issueOut)
    );

    always #10 clk = ~clk;

    // ========================================
    // Helpers
    // ========================================

    function automatic logic [31:0] recordField(input int idx, input int field);
        return caseMem[1 + idx * recordWords + field];
    endfunction

    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // One LFSR step per bit taken
    task automatic drawBits(input int count, output int value);
        int i;
        value = 0;
        for (i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsrState[0]);
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("FAILED %s expected %h actual %h", name, expected, actual);
        errorCount++;
        caseErrors++;
    endtask

    task automatic reportProblem(input string msg);
        $display("ERROR %s", msg);
        errorCount++;
        caseErrors++;
    endtask

    // Memory model returns NOPs past the last case
    task automatic presentRecord(input int idx);
        if (idx < numRecords) begin
            fetchedInstruction <= recordField(idx, 0);
            exeOverride        <= (recordField(idx, 1) != 0);
            exeData            <= imm16'(recordField(idx, 2));
        end else begin
            fetchedInstruction <= {opNop, 25'd0};
            exeOverride        <= 1'b0;
            exeData            <= '0;
        end
    endtask

    task automatic closeCase();
        if (gotCount != int'(expCount)) begin
            reportMismatch($sformatf("case %0d issue count", takenIdx), expCount, gotCount);
        end
        if (caseErrors == 0) begin
            $display("case %0d passed", takenIdx);
            casesPassed++;
        end else begin
            $display("case %0d failed with %0d errors", takenIdx, caseErrors);
            casesFailed++;
        end
        caseErrors = 0;
    endtask

    task automatic handleTake();
        addrWord expPc;
        if (takenIdx < 0) begin
            // Idle for one cycle after reset, then fetch at 0
            expPc = '0;
            if (cycle != 2) begin
                reportMismatch("reset first take cycle", 2, cycle);
            end
            if (programCounter !== expPc) begin
                reportMismatch("reset start pc", expPc, programCounter);
            end
        end else begin
            expPc = expNextPc;
            if (programCounter !== expPc) begin
                reportMismatch($sformatf("case %0d next pc", takenIdx), expPc, programCounter);
            end
            closeCase();
        end
        if (recIdx < numRecords) begin
            takenIdx   = recIdx;
            takePc     = expPc;
            takeCycle  = cycle;
            takenInstr = recordField(recIdx, 0);
            expNextPc  = recordField(recIdx, 3);
            expCount   = recordField(recIdx, 4);
            gotCount   = 0;
            if (recIdx == holdRecord) begin
                holdLeft = holdCycles;
            end
            recIdx++;
        end else begin
            finished = 1'b1;
        end
    endtask

    task automatic checkIssue();
        logic     isMul;
        issueKind expKind;
        stepIndex expStep;
        string    name;
        isMul   = (takenInstr[31:25] == opMul);
        expKind = isMul ? kindMicro : kindInstr;
        expStep = isMul ? stepIndex'(gotCount) : '0;
        name    = $sformatf("case %0d issue %0d", takenIdx, gotCount);
        if (takenIdx < 0) begin
            reportProblem("issueValid went high before any fetch");
        end else begin
            if (issueOut.kind !== expKind) begin
                reportMismatch({name, " kind"}, 32'(expKind), 32'(issueOut.kind));
            end
            if (issueOut.pc !== takePc) begin
                reportMismatch({name, " pc"}, takePc, issueOut.pc);
            end
            if (issueOut.instr !== takenInstr) begin
                reportMismatch({name, " instr"}, takenInstr, issueOut.instr);
            end
            if (issueOut.step !== expStep) begin
                reportMismatch({name, " step"}, 32'(expStep), 32'(issueOut.step));
            end
            if (!isMul && cycle != takeCycle + 1) begin
                reportMismatch({name, " latency"}, takeCycle + 1, cycle);
            end
        end
        gotCount++;
    endtask

    // Execute model holds returns until the first four issues are out
    task automatic driveCredit();
        logic held;
        held = (issuedTotal < int'(creditMax)) || (holdLeft > 0);
        if (holdLeft > 0) begin
            holdLeft--;
        end
        if (!held && dueQueue.size() > 0 && dueQueue[0] <= cycle) begin
            creditReturn <= 1'b1;
            void'(dueQueue.pop_front());
        end else begin
            creditReturn <= 1'b0;
        end
    endtask

    // ========================================
    // Per-cycle checks and stimulus
    // ========================================

    always @(posedge clk) begin
        if (rst) begin
            if (fetchTake || issueValid) begin
                reportProblem("fetchTake or issueValid high during reset");
            end
        end else begin
            cycle++;
            if (issueValid) begin
                issuedTotal++;
                drawBits(3, delay);
                dueQueue.push_back(cycle + 1 + delay);
                checkIssue();
            end
            outBefore = issuedTotal - returnedTotal;
            if (outBefore > int'(creditMax)) begin
                reportProblem("more issues outstanding than credits");
            end
            if (outBefore == int'(creditMax) && !creditReturn) begin
                stallCycles++;
                if (fetchTake) begin
                    reportProblem("fetch taken with no credit left");
                end
            end
            if (creditReturn) begin
                returnedTotal++;
            end
            if (fetchTake && !finished) begin
                handleTake();
            end
            driveCredit();
        end
        presentRecord(recIdx);
    end

    initial begin
        $readmemh("test/fetchCases.txt", caseMem);
        numRecords = int'(caseMem[0]);
        endErrors = 0;
        if (numRecords < 1 || numRecords > maxRecords) begin
            $display("ERROR case file gives %0d records, expected 1 to %0d",
                     numRecords, maxRecords);
            endErrors++;
        end
        timeLimit = numRecords * 40 + 100;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        while (!finished && cycle < timeLimit) begin
            @(posedge clk);
        end
        if (!finished) begin
            $display("ERROR run timed out after %0d cycles at case %0d", cycle, recIdx);
            endErrors++;
        end else if (stallCycles == 0) begin
            $display("ERROR credits never ran out, back-pressure was not exercised");
            endErrors++;
        end
        $display("%0d cases passed, %0d cases failed, %0d errors",
                 casesPassed, casesFailed, errorCount + endErrors);
        if (errorCount + endErrors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: test/fetchCases.txt
// First word is the record count, then one record per line
// instr override exeData expectedNextPc expectedIssues
0000001e
00100001 0 0000 00000004 1
00100002 0 0000 00000008 1
00100003 0 0000 0000000c 1
00100004 0 0000 00000010 1
00100005 0 0000 00000014 1
// B forward by 0x10, then NOP
c0000010 0 0000 00000024 1
c8000000 0 0000 00000028 0
00200001 0 0000 0000002c 1
// B backward by 8
c000fff8 0 0000 00000024 1
00200002 0 0000 00000028 1
// Override forward, word squashed
00300001 1 0100 00000128 0
a0001234 0 0000 0000012c 4
00400001 0 0000 00000130 1
// Override backward
00400002 1 fff0 00000120 0
c8000000 0 0000 00000124 0
a0005678 0 0000 00000128 4
00500001 0 0000 0000012c 1
// Credits withheld from here
00500002 0 0000 00000130 1
00500003 0 0000 00000134 1
00500004 0 0000 00000138 1
00500005 0 0000 0000013c 1
00500006 0 0000 00000140 1
// Override wins over B and over MUL
c0000100 1 0020 00000160 0
a0000001 1 0004 00000164 0
00600001 0 0000 00000168 1
a000abcd 0 0000 0000016c 4
00600002 0 0000 00000170 1
00600003 0 0000 00000174 1
c8000000 0 0000 00000178 0
00600004 0 0000 0000017c 1

// File: sim.f
design/fetchPkg.sv
design/pcSequencer.sv
design/mulMicrocode.sv
design/issueMerge.sv
design/fetchFrontEnd.sv
test/fetchFrontEndTb.sv

// File: Makefile
# Verilator flow for the fetch front end, run from the project root
VERILATOR ?= verilator
TOP       ?= fetchFrontEndTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= SOME TESTS FAILED
VFLAGS    ?= --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
